// File: common/fft_config.svh
////////////////////////////////////////////////////////////////////////////
// Widths and the 0.7071 constant for the W8 twiddle stage
// K707_NUM / 2^K707_SHIFT approximates 1/sqrt(2) and products are floored
////////////////////////////////////////////////////////////////////////////
`ifndef FFT_CONFIG_SVH
`define FFT_CONFIG_SVH

// Input and output component width
`define DATA_W 16

// Internal width, one bit more for a + b and b - a
`define SUM_W (`DATA_W + 1)

// 0.7071 as 46341 / 65536
`define K707_NUM 46341
`define K707_SHIFT 16

// Enabled cycles from ds to dv, prep 1 + multiplier 3 + output 1
`define STAGE_LAT 5

`endif

// File: common/fft_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the W8 twiddle stage and its testbench
// Widths come from fft_config.svh
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fft_config.svh"

package fft_pkg;

  // One real or imaginary component at the stage ports
  typedef logic signed [`DATA_W-1:0] sample_t;

  // Component after the sum or difference for k = 1 and k = 3
  typedef logic signed [`SUM_W-1:0] sum_t;

  // Twiddle exponent, the stage applies W8^k
  typedef logic [1:0] tw_idx_t;

  // Exponent values
  localparam tw_idx_t W8_0 = 2'd0;   // 1
  localparam tw_idx_t W8_1 = 2'd1;   // (1 - j) * 0.7071
  localparam tw_idx_t W8_2 = 2'd2;   // -j
  localparam tw_idx_t W8_3 = 2'd3;   // (-1 - j) * 0.7071

  // Output clamp limits
  localparam sample_t SAMPLE_MAX = {1'b0, {(`DATA_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(`DATA_W-1){1'b0}}};

endpackage

`default_nettype wire

// File: src/twiddle_prep.sv
////////////////////////////////////////////////////////////////////////////
// Input side of the W8 stage, captures a sample on an enabled ds
// Leaves only a real scale of 1 or 0.7071 for the multiplier
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fft_config.svh"

module twiddle_prep (
  input  wire                CLK,
  input  wire                rst_n,
  input  wire                ed,
  input  wire                ds,
  input  wire fft_pkg::sample_t dr,
  input  wire fft_pkg::sample_t di,
  input  wire fft_pkg::tw_idx_t k,
  output fft_pkg::sum_t      pr,
  output fft_pkg::sum_t      pi,
  output logic               scale,
  output logic               ps
);

  import fft_pkg::*;

  sum_t a;                          // Sign-extended real input
  sum_t b;                          // Sign-extended imaginary input
  sum_t nr;
  sum_t ni;
  sum_t nneg;                       // -a - b, clamped
  logic nscale;
  logic signed [`SUM_W:0] nsum_w;   // -a - b one bit wider

  assign a = sum_t'(dr);
  assign b = sum_t'(di);

  // Only a = b = min overflows here, the scaled result saturates anyway
  assign nsum_w = -((`SUM_W+1)'(a) + (`SUM_W+1)'(b));
  assign nneg = (nsum_w[`SUM_W] != nsum_w[`SUM_W-1]) ?
                {1'b0, {(`SUM_W-1){1'b1}}} : nsum_w[`SUM_W-1:0];

  always_comb begin
    nr = a;
    ni = b;
    nscale = 1'b0;
    case (k)
      W8_1: begin
        nr = a + b;
        ni = b - a;
        nscale = 1'b1;
      end
      W8_2: begin
        nr = b;      // Multiply by -j
        ni = -a;
      end
      W8_3: begin
        nr = b - a;
        ni = nneg;
        nscale = 1'b1;
      end
      default: ;     // W8_0 passes the sample through
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ps    <= 1'b0;
      scale <= 1'b0;
    end else if (ed) begin
      ps <= ds;
      if (ds) scale <= nscale;
    end
  end

  always_ff @(posedge CLK) begin
    if (ed && ds) begin
      pr <= nr;
      pi <= ni;
    end
  end

endmodule

`default_nettype wire

// File: mult_707/mult_707_serial.sv
////////////////////////////////////////////////////////////////////////////
// Serial 0.7071 multiplier with the real part one enabled cycle after ps
// ps strobes must be at least two enabled cycles apart and ms follows by three
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fft_config.svh"

module mult_707_serial (
  input  wire             CLK,
  input  wire             rst_n,
  input  wire             ed,
  input  wire             ps,
  input  wire fft_pkg::sum_t pr,
  input  wire fft_pkg::sum_t pi,
  input  wire             scale,
  output fft_pkg::sum_t   mr,
  output fft_pkg::sum_t   mi,
  output logic            ms
);

  import fft_pkg::*;

  // Constant is below 1.0 so K707_SHIFT bits plus a sign bit hold it
  localparam int K_W    = `K707_SHIFT + 1;
  localparam int PROD_W = `SUM_W + K_W;
  localparam logic signed [K_W-1:0] K707 = K_W'(`K707_NUM);

  sum_t dx;                           // Operand, real then imaginary
  sum_t pih;                          // Imaginary part waits here
  sum_t prod_r;                       // Holds the real product when mr loads
  sum_t prod_nxt;
  logic signed [PROD_W-1:0] prod_full;
  logic [2:0] ms_sr;                  // ps delayed by 1, 2 and 3 enabled cycles
  logic [1:0] sc_sr;                  // scale alongside ms_sr[1:0]
  logic mpy_en;

  // Real pass uses the first scale stage and imaginary pass the second
  assign mpy_en = ms_sr[0] ? sc_sr[0] : sc_sr[1];

  assign prod_full = PROD_W'(dx) * PROD_W'(K707);
  // Arithmetic shift floors toward minus infinity
  assign prod_nxt = mpy_en ? sum_t'(prod_full >>> `K707_SHIFT) : dx;

  assign ms = ms_sr[2];

  // Strobe and scale shift registers
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ms_sr <= '0;
      sc_sr <= '0;
    end else if (ed) begin
      ms_sr <= {ms_sr[1:0], ps};
      sc_sr <= {sc_sr[0], scale};
    end
  end

  // Operand select, shared multiplier and result capture
  always_ff @(posedge CLK) begin
    if (ed) begin
      if (ps) begin
        dx  <= pr;
        pih <= pi;
      end else begin
        dx <= pih;
      end

      prod_r <= prod_nxt;

      // Imaginary product is on prod_nxt in this cycle
      if (ms_sr[1]) begin
        mr <= prod_r;
        mi <= prod_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/output_sat.sv
////////////////////////////////////////////////////////////////////////////
// Output side, clamps to DATA_W and holds dor/doi between dv pulses
// dv is one enabled cycle wide and is forced low while ed is low
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fft_config.svh"

module output_sat (
  input  wire                CLK,
  input  wire                rst_n,
  input  wire                ed,
  input  wire                ms,
  input  wire fft_pkg::sum_t mr,
  input  wire fft_pkg::sum_t mi,
  output fft_pkg::sample_t   dor,
  output fft_pkg::sample_t   doi,
  output logic               dv
);

  import fft_pkg::*;

  logic dv_q;

  // Overflow when the two top bits differ
  function automatic sample_t sat(input sum_t x);
    if (x[`SUM_W-1] != x[`SUM_W-2])
      sat = x[`SUM_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
    else
      sat = sample_t'(x);
  endfunction

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      dv_q <= 1'b0;
      dor  <= '0;
      doi  <= '0;
    end else if (ed) begin
      dv_q <= ms;
      if (ms) begin
        dor <= sat(mr);
        doi <= sat(mi);
      end
    end
  end

  assign dv = dv_q & ed;  // Stalled cycles do not repeat the pulse

endmodule

`default_nettype wire

// File: src/w8_twiddle_top.sv
////////////////////////////////////////////////////////////////////////////
// W8^k twiddle stage, dv follows ds by STAGE_LAT enabled cycles
// ds strobes at least two enabled cycles apart, ed stalls everything
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module w8_twiddle_top (
  input  wire                   CLK,
  input  wire                   rst_n,
  input  wire                   ed,
  input  wire                   ds,
  input  wire fft_pkg::sample_t dr,
  input  wire fft_pkg::sample_t di,
  input  wire fft_pkg::tw_idx_t k,
  output wire fft_pkg::sample_t dor,
  output wire fft_pkg::sample_t doi,
  output wire                   dv
);

  import fft_pkg::*;

  wire sum_t pr;
  wire sum_t pi;
  wire sum_t mr;
  wire sum_t mi;
  wire       scale;
  wire       ps;
  wire       ms;

  twiddle_prep u_prep (
    .CLK   (CLK),
    .rst_n (rst_n),
    .ed    (ed),
    .ds    (ds),
    .dr    (dr),
    .di    (di),
    .k     (k),
    .pr    (pr),
    .pi    (pi),
    .scale (scale),
    .ps    (ps)
  );

  mult_707_serial u_mult (
    .CLK   (CLK),
    .rst_n (rst_n),
    .ed    (ed),
    .ps    (ps),
    .pr    (pr),
    .pi    (pi),
    .scale (scale),
    .mr    (mr),
    .mi    (mi),
    .ms    (ms)
  );

  output_sat u_sat (
    .CLK   (CLK),
    .rst_n (rst_n),
    .ed    (ed),
    .ms    (ms),
    .mr    (mr),
    .mi    (mi),
    .dor   (dor),
    .doi   (doi),
    .dv    (dv)
  );

endmodule

`default_nettype wire

// File: dv/w8_twiddle_asserts.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks bound into mult_707_serial by the testbench
// Assumes ps strobes at least two enabled cycles apart
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module w8_twiddle_asserts (
  input wire                CLK,
  input wire                rst_n,
  input wire                ed,
  input wire                ps,
  input wire                ms,
  input wire [2:0]          ms_sr,
  input wire [1:0]          sc_sr,
  input wire fft_pkg::sum_t mr,
  input wire fft_pkg::sum_t mi,
  input wire fft_pkg::sum_t dx,
  input wire fft_pkg::sum_t pih
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;
  logic [2:0] ps_hist;               // ps seen at the last three enabled edges

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ps_hist <= '0;
    end else if (ed) begin
      ps_hist <= {ps_hist[1:0], ps};
    end
  end

  // Nothing moves on a stalled edge
  a_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    !ed |=> (ms_sr === $past(ms_sr)) && (sc_sr === $past(sc_sr)) &&
            (dx === $past(dx)) && (pih === $past(pih)) &&
            (mr === $past(mr)) && (mi === $past(mi)))
    else begin
      $error("mult_707_serial register changed while ed was low");
      fail_count++;
    end

  // ms marks the ps taken three enabled edges back
  a_delay: assert property (@(posedge CLK) disable iff (!rst_n)
    ms === ps_hist[2])
    else begin
      $error("ms does not follow ps by three enabled cycles");
      fail_count++;
    end

  a_gap: assert property (@(posedge CLK) disable iff (!rst_n)
    ed && ms |=> !ms)
    else begin
      $error("two ms pulses in adjacent enabled cycles");
      fail_count++;
    end

  a_known: assert property (@(posedge CLK) disable iff (!rst_n)
    ms |-> !$isunknown(mr) && !$isunknown(mi))
    else begin
      $error("mr or mi unknown while ms is high");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: dv/tb_w8_twiddle.sv
////////////////////////////////////////////////////////////////////////////
// Directed tests for w8_twiddle_top against a behavioral reference model
// Inputs change 2 ns after the rising edge and outputs are read on the falling edge
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fft_config.svh"

module tb_w8_twiddle;

  timeunit 1ns;
  timeprecision 100ps;

  import fft_pkg::*;

  localparam int NUM_SAMPLES    = 51;   // Sum over all tests
  localparam int TIMEOUT_CYCLES = NUM_SAMPLES * 12 + 200;
  localparam longint SAT_HI = (longint'(1) <<< (`DATA_W - 1)) - 1;
  localparam longint SAT_LO = -(longint'(1) <<< (`DATA_W - 1));

  logic    CLK = 1'b0;
  logic    rst_n;
  logic    ed;
  logic    ds;
  sample_t dr;
  sample_t di;
  tw_idx_t k;
  sample_t dor;
  sample_t doi;
  logic    dv;

  integer seed = 18772;
  int     cycle_cnt = 0;
  int     en_cnt = 0;        // Enabled cycles since reset
  int     value_errs = 0;
  int     timing_errs = 0;
  int     other_errs = 0;

  // Expected outputs and dv times in issue order
  sample_t exp_r[$];
  sample_t exp_i[$];
  int      exp_t[$];

  logic    prev_ed = 1'b0;
  sample_t prev_dor = '0;
  sample_t prev_doi = '0;
  sample_t ref_r;
  sample_t ref_i;

  w8_twiddle_top DUT (
    .CLK   (CLK),
    .rst_n (rst_n),
    .ed    (ed),
    .ds    (ds),
    .dr    (dr),
    .di    (di),
    .k     (k),
    .dor   (dor),
    .doi   (doi),
    .dv    (dv)
  );

  bind mult_707_serial w8_twiddle_asserts u_asserts (
    .CLK   (CLK),
    .rst_n (rst_n),
    .ed    (ed),
    .ps    (ps),
    .ms    (ms),
    .ms_sr (ms_sr),
    .sc_sr (sc_sr),
    .mr    (mr),
    .mi    (mi),
    .dx    (dx),
    .pih   (pih)
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d samples never delivered",
               cycle_cnt, exp_t.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic sample_t saturate(input longint x);
    if (x > SAT_HI) return sample_t'(SAT_HI);
    if (x < SAT_LO) return sample_t'(SAT_LO);
    return sample_t'(x);
  endfunction

  // Floor of x * 0.7071
  function automatic longint scale_707(input longint x);
    return (x * longint'(`K707_NUM)) >>> `K707_SHIFT;
  endfunction

  function automatic void reference_twiddle(input sample_t r, input sample_t i,
                                            input tw_idx_t kk,
                                            output sample_t er, output sample_t ei);
    longint a;
    longint b;
    longint xr;
    longint xi;
    a = longint'(r);
    b = longint'(i);
    case (kk)
      2'd1: begin
        xr = scale_707(a + b);
        xi = scale_707(b - a);
      end
      2'd2: begin
        xr = b;              // Rotation by -j
        xi = -a;
      end
      2'd3: begin
        xr = scale_707(b - a);
        xi = scale_707(-a - b);
      end
      default: begin
        xr = a;
        xi = b;
      end
    endcase
    er = saturate(xr);
    ei = saturate(xi);
  endfunction

  function automatic sample_t rand_sample();
    return sample_t'($random(seed));
  endfunction

  task automatic expect_sample(input string what, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic dv_latency_check(input int got, input int exp);
    if (got != exp) begin
      timing_errs++;
      $display("Mismatch at %0t: dv at enabled cycle %0d, expected %0d", $time, got, exp);
    end
  endtask

  // Scoreboard, all signals are settled at the falling edge
  always @(negedge CLK) begin : monitor
    if (rst_n) begin
      if (ed && ds) begin
        reference_twiddle(dr, di, k, ref_r, ref_i);
        exp_r.push_back(ref_r);
        exp_i.push_back(ref_i);
        exp_t.push_back(en_cnt + `STAGE_LAT);
      end
      if (!ed && dv) begin
        other_errs++;
        $display("dv is high while ed is low at %0t", $time);
      end
      // Outputs only move on an enabled edge that raises dv
      if (!prev_ed || (ed && !dv)) begin
        expect_sample("dor hold", dor, prev_dor);
        expect_sample("doi hold", doi, prev_doi);
      end
      if (ed && dv) begin
        if (exp_t.size() == 0) begin
          other_errs++;
          $display("dv pulsed at %0t with no sample in flight", $time);
        end else begin
          dv_latency_check(en_cnt, exp_t.pop_front());
          expect_sample("dor", dor, exp_r.pop_front());
          expect_sample("doi", doi, exp_i.pop_front());
        end
      end
      if (ed) en_cnt++;
    end
    prev_ed  = ed;
    prev_dor = dor;
    prev_doi = doi;
  end

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  // One ds cycle then one idle cycle with junk on the data inputs
  task automatic send_sample(input sample_t r, input sample_t i, input tw_idx_t kk);
    next_cycle();
    ed = 1'b1;
    ds = 1'b1;
    dr = r;
    di = i;
    k  = kk;
    next_cycle();
    ds = 1'b0;
    dr = rand_sample();
    di = rand_sample();
    k  = tw_idx_t'($random(seed));
  endtask

  task automatic drain();
    ed = 1'b1;
    while (exp_t.size() != 0) next_cycle();
    repeat (2) next_cycle();   // Catch a stray dv
  endtask

  task automatic unscaled_rotations();
    for (int n = 0; n < 8; n++) begin
      send_sample(rand_sample(), rand_sample(), (n < 4) ? W8_0 : W8_2);
      drain();
    end
  endtask

  task automatic scaled_random();
    for (int n = 0; n < 24; n++) begin
      send_sample(rand_sample(), rand_sample(), n[0] ? W8_3 : W8_1);
      drain();
    end
  endtask

  task automatic extreme_inputs();
    send_sample(SAMPLE_MIN, SAMPLE_MIN, W8_3);
    send_sample(SAMPLE_MAX, SAMPLE_MAX, W8_1);
    send_sample(SAMPLE_MIN, SAMPLE_MIN, W8_1);
    send_sample(SAMPLE_MIN, SAMPLE_MAX, W8_3);
    send_sample(SAMPLE_MIN, '0, W8_2);
    send_sample(SAMPLE_MAX, SAMPLE_MIN, W8_1);
    drain();
  endtask

  // Three samples in flight at once
  task automatic back_to_back();
    for (int n = 0; n < 10; n++)
      send_sample(rand_sample(), rand_sample(), tw_idx_t'($random(seed)));
    drain();
  endtask

  task automatic stalled_flight(input int offset, input int len);
    send_sample(rand_sample(), rand_sample(), W8_1);
    repeat (offset) next_cycle();
    ed = 1'b0;
    ds = 1'b1;                 // Ignored while stalled
    dr = rand_sample();
    repeat (len) next_cycle();
    ed = 1'b1;
    ds = 1'b0;
    drain();
  endtask

  initial begin
    int total;
    rst_n = 1'b0;
    ed    = 1'b0;
    ds    = 1'b0;
    dr    = '0;
    di    = '0;
    k     = W8_0;
    repeat (16) @(posedge CLK);
    #2;
    rst_n = 1'b1;
    ed    = 1'b1;
    expect_sample("dor after reset", dor, '0);
    expect_sample("doi after reset", doi, '0);
    unscaled_rotations();
    scaled_random();
    extreme_inputs();
    back_to_back();
    stalled_flight(0, 3);
    stalled_flight(2, 4);
    stalled_flight(4, 3);      // Stall lands on the dv cycle
    total = value_errs + timing_errs + other_errs + DUT.u_mult.u_asserts.fail_count;
    $display("Errors: value %0d, timing %0d, other %0d, assertion %0d",
             value_errs, timing_errs, other_errs, DUT.u_mult.u_asserts.fail_count);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/fft_pkg.sv
src/twiddle_prep.sv
mult_707/mult_707_serial.sv
src/output_sat.sv
src/w8_twiddle_top.sv
dv/w8_twiddle_asserts.sv
dv/tb_w8_twiddle.sv

// File: Makefile
# Verilator build and run of the W8 twiddle stage testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_w8_twiddle
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
